// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = routerOutputTb
FILELIST  = routerOutput.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/flitPortIf.sv ====
interface flitPortIf;

  logic               req;
  routerPkg::FlitType flitType;
  routerPkg::PktLength length;
  routerPkg::FlitData payload;

  modport src (
    output req,
    output flitType,
    output length,
    output payload
  );

  modport arb (
    input req,
    input flitType,
    input length
  );

  // the switch needs req as well to qualify the output valid
  modport sw (
    input req,
    input flitType,
    input payload
  );

endinterface

// ==== design/flitSwitch.sv ====
module flitSwitch (
  input  routerPkg::PortMask grant,
  flitPortIf.sw              portL,
  flitPortIf.sw              portN,
  flitPortIf.sw              portE,
  flitPortIf.sw              portW,
  flitPortIf.sw              portS,
  output logic               outValid,
  output routerPkg::FlitType outFlitType,
  output routerPkg::FlitData outPayload
);

  routerPkg::PortMask req;
  routerPkg::FlitType flitType [routerPkg::NumPorts];
  routerPkg::FlitData payload [routerPkg::NumPorts];

  assign req = {portS.req, portW.req, portE.req, portN.req, portL.req};

  assign flitType[0] = portL.flitType;
  assign flitType[1] = portN.flitType;
  assign flitType[2] = portE.flitType;
  assign flitType[3] = portW.flitType;
  assign flitType[4] = portS.flitType;

  assign payload[0] = portL.payload;
  assign payload[1] = portN.payload;
  assign payload[2] = portE.payload;
  assign payload[3] = portW.payload;
  assign payload[4] = portS.payload;

  assign outValid = |(grant & req);

  // at most one term of this and-or mux survives because grant is one-hot or zero
  always_comb
  begin
    outFlitType = '0;
    outPayload = '0;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      outFlitType = outFlitType | (flitType[i] & {routerPkg::FlitTypeWidth{grant[i]}});
      outPayload = outPayload | (payload[i] & {routerPkg::FlitDataWidth{grant[i]}});
    end
  end

endmodule

// ==== design/holdTimer.sv ====
module holdTimer (
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::FlitType  flitType,
  input  routerPkg::PktLength length,
  input  logic                run,
  output logic                expired
);

  routerPkg::PktLength limit;
  routerPkg::PktLength count;

  // a header flit on this port reloads the limit, even mid-grant
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitType == routerPkg::HeaderFlit)
    begin
      limit <= length;
    end
  end

  // count only runs while the arbiter keeps this port as holder
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign expired = (count == limit);

endmodule

// ==== design/outputArbiter.sv ====
module outputArbiter (
  input  logic               clk,
  input  logic               rst,
  flitPortIf.arb             portL,
  flitPortIf.arb             portN,
  flitPortIf.arb             portE,
  flitPortIf.arb             portW,
  flitPortIf.arb             portS,
  output routerPkg::PortMask grant
);

  routerPkg::ArbState  state;
  routerPkg::ArbState  nextState;
  routerPkg::PortMask  req;
  routerPkg::PortMask  expired;
  routerPkg::PortMask  run;
  routerPkg::FlitType  flitType [routerPkg::NumPorts];
  routerPkg::PktLength length [routerPkg::NumPorts];
  logic                keep;

  assign req = {portS.req, portW.req, portE.req, portN.req, portL.req};

  assign flitType[0] = portL.flitType;
  assign flitType[1] = portN.flitType;
  assign flitType[2] = portE.flitType;
  assign flitType[3] = portW.flitType;
  assign flitType[4] = portS.flitType;

  assign length[0] = portL.length;
  assign length[1] = portN.length;
  assign length[2] = portE.length;
  assign length[3] = portW.length;
  assign length[4] = portS.length;

  for (genvar i = 0; i < routerPkg::NumPorts; i++)
  begin : genTimer
    holdTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flitType (flitType[i]),
      .length   (length[i]),
      .run      (run[i]),
      .expired  (expired[i])
    );
  end

  // drop the Idle bit, so grant is zero in Idle
  assign grant = state[routerPkg::NumPorts:1];

  // the holder stays while it still requests and its timer has not run out
  assign keep = |(grant & req & ~expired);

  // only the kept holder's timer counts
  assign run = keep ? grant : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::Idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    int unsigned holder;
    int unsigned idx;
    logic        found;

    // in Idle, pretend S held the grant so the scan starts at L
    holder = routerPkg::NumPorts - 1;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      if (grant[i])
      begin
        holder = i;
      end
    end

    found = 1'b0;
    nextState = routerPkg::Idle;
    if (keep)
    begin
      nextState = state;
      found = 1'b1;
    end

    // rotate from just after the holder, which itself comes last
    for (int k = 1; k <= routerPkg::NumPorts; k++)
    begin
      idx = holder + k;
      if (idx >= routerPkg::NumPorts)
      begin
        idx = idx - routerPkg::NumPorts;
      end
      if (!found && req[idx])
      begin
        nextState = routerPkg::ArbState'({routerPkg::PortMask'(1) << idx, 1'b0});
        found = 1'b1;
      end
    end
  end

endmodule

// ==== design/routerOutput.sv ====
module routerOutput (
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::PortMask  req,
  input  routerPkg::FlitType  flitType [routerPkg::NumPorts],
  input  routerPkg::PktLength length [routerPkg::NumPorts],
  input  routerPkg::FlitData  payload [routerPkg::NumPorts],
  output routerPkg::PortMask  grant,
  output logic                outValid,
  output routerPkg::FlitType  outFlitType,
  output routerPkg::FlitData  outPayload
);

  flitPortIf portL ();
  flitPortIf portN ();
  flitPortIf portE ();
  flitPortIf portW ();
  flitPortIf portS ();

  // port order matches the PortMask bits: L, N, E, W, S
  assign {portS.req, portW.req, portE.req, portN.req, portL.req} = req;

  assign portL.flitType = flitType[0];
  assign portN.flitType = flitType[1];
  assign portE.flitType = flitType[2];
  assign portW.flitType = flitType[3];
  assign portS.flitType = flitType[4];

  assign portL.length = length[0];
  assign portN.length = length[1];
  assign portE.length = length[2];
  assign portW.length = length[3];
  assign portS.length = length[4];

  assign portL.payload = payload[0];
  assign portN.payload = payload[1];
  assign portE.payload = payload[2];
  assign portW.payload = payload[3];
  assign portS.payload = payload[4];

  outputArbiter arbiter (
    .clk   (clk),
    .rst   (rst),
    .portL (portL),
    .portN (portN),
    .portE (portE),
    .portW (portW),
    .portS (portS),
    .grant (grant)
  );

  flitSwitch switch (
    .grant       (grant),
    .portL       (portL),
    .portN       (portN),
    .portE       (portE),
    .portW       (portW),
    .portS       (portS),
    .outValid    (outValid),
    .outFlitType (outFlitType),
    .outPayload  (outPayload)
  );

endmodule

// ==== design/routerPkg.sv ====
package routerPkg;

  // the router inputs are L, N, E, W and S
  localparam int NumPorts = 5;

  localparam int FlitTypeWidth = 3;
  localparam int PktLengthWidth = 12;
  localparam int FlitDataWidth = 32;

  typedef logic [FlitTypeWidth-1:0] FlitType;

  // the length field is also the hold limit in cycles
  typedef logic [PktLengthWidth-1:0] PktLength;

  typedef logic [FlitDataWidth-1:0] FlitData;

  // bit 0 is L, then N, E, W, and bit 4 is S
  typedef logic [NumPorts-1:0] PortMask;

  // only a header flit carries a valid length
  localparam FlitType HeaderFlit = FlitType'(1);

  // in the one-hot state bit 0 is Idle and bits 5:1 line up with PortMask
  typedef enum logic [NumPorts:0] {
    Idle   = 6'b000001,
    GrantL = 6'b000010,
    GrantN = 6'b000100,
    GrantE = 6'b001000,
    GrantW = 6'b010000,
    GrantS = 6'b100000
  } ArbState;

endpackage

// ==== dv/clockGen.sv ====
module clockGen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset spans the first eight rising edges
  initial
  begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== dv/routerOutputTb.sv ====
module routerOutputTb;

  logic                clk;
  logic                rst;
  routerPkg::PortMask  req;
  routerPkg::FlitType  flitType [routerPkg::NumPorts];
  routerPkg::PktLength length [routerPkg::NumPorts];
  routerPkg::FlitData  payload [routerPkg::NumPorts];
  routerPkg::PortMask  grant;
  logic                outValid;
  routerPkg::FlitType  outFlitType;
  routerPkg::FlitData  outPayload;

  // stimulus table with the per-port fields written in the order S, W, E, N, L
  routerPkg::PortMask stepReq [$];
  logic [4:0][2:0]    stepType [$];
  logic [4:0][11:0]   stepLen [$];
  int                 stepCycles [$];

  routerPkg::PortMask  refGrant = '0;
  routerPkg::PktLength refLimit [routerPkg::NumPorts];
  routerPkg::PktLength refCount [routerPkg::NumPorts];

  integer seed = 32'hf689_f0e2;
  int     totalCycles = 0;
  int     cycleLimit = 0;
  int     cycleCount = 0;
  int     checkCount = 0;
  int     errorCount = 0;
  int     stepErrors = 0;

  clockGen clocks (
    .clk (clk),
    .rst (rst)
  );

  routerOutput dut (
    .clk, .rst, .req, .flitType, .length, .payload,
    .grant, .outValid, .outFlitType, .outPayload
  );

  task automatic addStep(input routerPkg::PortMask r, input logic [4:0][2:0] t,
                         input logic [4:0][11:0] l, input int c);
    stepReq.push_back(r);
    stepType.push_back(t);
    stepLen.push_back(l);
    stepCycles.push_back(c);
    totalCycles += c;
  endtask

  // table flit types go out on the first cycle of a step and a distinct body code per port after it
  task automatic driveStep(input int s, input bit first);
    req <= stepReq[s];
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      flitType[i] <= first ? stepType[s][i] : 3'(2 + i);
      length[i] <= stepLen[s][i];
      payload[i] <= $random(seed);
    end
  endtask

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      errorCount++;
      stepErrors++;
    end
  endtask

  // reference model of the grant rules, evaluated with the values seen at each edge
  always @(posedge clk)
  begin
    routerPkg::PortMask expiredNow;
    routerPkg::PortMask nextGrant;
    int                 holderIdx;
    int                 start;
    int                 idx;
    bit                 keepHolder;
    bit                 found;
    if (rst)
    begin
      refGrant = '0;
      for (int i = 0; i < routerPkg::NumPorts; i++)
      begin
        refLimit[i] = '0;
        refCount[i] = '0;
      end
    end
    else
    begin
      holderIdx = -1;
      keepHolder = 1'b0;
      for (int i = 0; i < routerPkg::NumPorts; i++)
      begin
        expiredNow[i] = (refCount[i] == refLimit[i]);
        if (refGrant[i])
        begin
          holderIdx = i;
        end
      end
      if (holderIdx >= 0)
      begin
        keepHolder = req[holderIdx] && !expiredNow[holderIdx];
      end
      nextGrant = refGrant;
      if (!keepHolder)
      begin
        // scan starts after the holder, or at L from idle
        nextGrant = '0;
        found = 1'b0;
        start = holderIdx + 1;
        for (int k = 0; k < routerPkg::NumPorts; k++)
        begin
          idx = (start + k) % routerPkg::NumPorts;
          if (!found && req[idx])
          begin
            nextGrant[idx] = 1'b1;
            found = 1'b1;
          end
        end
      end
      for (int i = 0; i < routerPkg::NumPorts; i++)
      begin
        if (flitType[i] == routerPkg::HeaderFlit)
        begin
          refLimit[i] = length[i];
        end
        refCount[i] = (keepHolder && i == holderIdx) ? refCount[i] + 1'b1 : '0;
      end
      refGrant = nextGrant;
    end
  end

  always @(negedge clk)
  begin
    routerPkg::FlitType expType;
    routerPkg::FlitData expPayload;
    logic               expValid;
    if (!rst)
    begin
      expType = '0;
      expPayload = '0;
      expValid = 1'b0;
      for (int i = 0; i < routerPkg::NumPorts; i++)
      begin
        if (refGrant[i])
        begin
          expType = flitType[i];
          expPayload = payload[i];
          expValid = req[i];
        end
      end
      compareValue("grant", 32'(refGrant), 32'(grant));
      compareValue("outValid", 32'(expValid), 32'(outValid));
      compareValue("outFlitType", 32'(expType), 32'(outFlitType));
      compareValue("outPayload", expPayload, outPayload);
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: the run did not end within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    req = '0;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      flitType[i] = '0;
      length[i] = '0;
      payload[i] = '0;
    end
    addStep(5'b00000, {5{3'd2}}, {5{12'd0}}, 3);
    addStep(5'b10101, {5{routerPkg::HeaderFlit}}, {5{12'd2}}, 12);
    addStep(5'b01010, {5{routerPkg::HeaderFlit}}, {5{12'd0}}, 6);
    addStep(5'b00100, {5{routerPkg::HeaderFlit}}, {5{12'd20}}, 3);
    addStep(5'b11001, {5{3'd2}}, {5{12'd20}}, 3);
    addStep(5'b10001, {5{3'd2}}, {5{12'd20}}, 3);
    addStep(5'b00001, {5{3'd2}}, {5{12'd20}}, 3);
    addStep(5'b00010, {3'd2, 3'd2, 3'd2, routerPkg::HeaderFlit, 3'd2}, {5{12'd1}}, 8);
    addStep(5'b00000, {5{3'd2}}, {5{12'd0}}, 3);
    cycleLimit = totalCycles + 50;

    wait (!rst);
    @(posedge clk);
    for (int s = 0; s < stepReq.size(); s++)
    begin
      stepErrors = 0;
      driveStep(s, 1'b1);
      for (int c = 1; c < stepCycles[s]; c++)
      begin
        @(posedge clk);
        driveStep(s, 1'b0);
      end
      @(posedge clk);
      $display("step %0d req=%b cycles=%0d mismatches=%0d",
               s, stepReq[s], stepCycles[s], stepErrors);
    end

    $display("steps=%0d checks=%0d errors=%0d assertion failures=%0d",
             stepReq.size(), checkCount, errorCount, dut.props.failCount);
    if (errorCount == 0 && dut.props.failCount == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/routerOutput_properties.sv ====
module routerOutputProperties (
  input logic               clk,
  input logic               rst,
  input routerPkg::PortMask req,
  input routerPkg::PortMask grant,
  input routerPkg::PortMask expired,
  input logic               outValid
);

  int failCount = 0;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else
    begin
      $error("grant has more than one bit set");
      failCount++;
    end

  validNeedsGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> grant != '0)
    else
    begin
      $error("output valid without a grant");
      failCount++;
    end

  // a requesting holder whose timer has not run out must keep the grant
  holderKept: assert property (@(posedge clk) disable iff (rst)
    |(grant & req & ~expired) |=> grant == $past(grant))
    else
    begin
      $error("grant moved away from a holder that was still entitled to it");
      failCount++;
    end

endmodule

bind routerOutput routerOutputProperties props (
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .grant    (grant),
  .expired  (arbiter.expired),
  .outValid (outValid)
);

// ==== routerOutput.f ====
design/routerPkg.sv
design/flitPortIf.sv
design/holdTimer.sv
design/outputArbiter.sv
design/flitSwitch.sv
design/routerOutput.sv
dv/clockGen.sv
dv/routerOutput_properties.sv
dv/routerOutputTb.sv
